// ==== project.f ====
common/cpu_pkg.sv
common/rf_if.sv
verilog/pipe_reg.sv
verilog/word_mem.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/hazard_unit.sv
verilog/prog_loader.sv
cpu/decode_stage.sv
cpu/cpu.sv
verification/cpu_props.sv
verification/cpu_tb.sv

// ==== verification/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

  localparam int NPROG        = 4;
  localparam int PERIOD       = 4;
  localparam int RESET_CYCLES = 8;
  localparam int ROW_CYCLES   = 64;   // Budget per program table row
  localparam int MAX_WORDS    = 16;
  localparam int HLT_LIMIT    = 48;
  localparam int DRAIN_CYCLES = 6;
  localparam int ACK_LIMIT    = 8;
  localparam int WATCHDOG_CYCLES =
    NPROG * (ROW_CYCLES + RESET_CYCLES + 2 + 2 * MAX_WORDS);

  localparam cpu_pkg::word_t HALT = 16'hF000;

  localparam cpu_pkg::opcode_e OP_ADD = cpu_pkg::OP_ADD;
  localparam cpu_pkg::opcode_e OP_SUB = cpu_pkg::OP_SUB;
  localparam cpu_pkg::opcode_e OP_XOR = cpu_pkg::OP_XOR;
  localparam cpu_pkg::opcode_e OP_SLL = cpu_pkg::OP_SLL;
  localparam cpu_pkg::opcode_e OP_SRA = cpu_pkg::OP_SRA;
  localparam cpu_pkg::opcode_e OP_LW  = cpu_pkg::OP_LW;
  localparam cpu_pkg::opcode_e OP_SW  = cpu_pkg::OP_SW;
  localparam cpu_pkg::opcode_e OP_LLB = cpu_pkg::OP_LLB;
  localparam cpu_pkg::opcode_e OP_LHB = cpu_pkg::OP_LHB;

  // Branch condition codes
  localparam int CC_EQ = 1;
  localparam int CC_GT = 2;
  localparam int CC_LT = 3;
  localparam int CC_LE = 5;
  localparam int CC_OV = 6;

  logic              clk;
  logic              rst_n;
  logic              prog_req;
  cpu_pkg::word_t    prog_addr;
  cpu_pkg::word_t    prog_data;
  logic              prog_last;
  logic              prog_ack;
  logic              hlt;
  cpu_pkg::word_t    pc;
  logic              wb_valid;
  cpu_pkg::reg_idx_t wb_reg;
  cpu_pkg::word_t    wb_data;

  cpu_pkg::word_t code_q [$];   // All programs back to back
  logic [19:0]    wb_q [$];     // {register, value} in program order
  int             prog_len [NPROG];
  int             hlt_idx [NPROG];
  int             wb_cnt [NPROG];

  cpu cpu_inst (
    .clk, .rst_n, .prog_req, .prog_addr, .prog_data, .prog_last, .prog_ack,
    .hlt, .pc, .wb_valid, .wb_reg, .wb_data
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * PERIOD);
    report_failure("Watchdog expired before all programs finished");
  end

  ////////////////////
  // Instruction encoding
  ////////////////////
  function automatic cpu_pkg::word_t rr_instr(input cpu_pkg::opcode_e op, input int rd,
      input int rs, input int low);
    return {op, 4'(rd), 4'(rs), 4'(low)};  // low is rt, shift amount or offset
  endfunction

  function automatic cpu_pkg::word_t imm8_instr(input cpu_pkg::opcode_e op, input int rd,
      input logic [7:0] imm);
    return {op, 4'(rd), imm};
  endfunction

  function automatic cpu_pkg::word_t branch_instr(input int cond, input int off);
    return {4'hC, 3'(cond), 9'(off)};
  endfunction

  task automatic build_table();
    code_q = '{
      // Dependent chains, then saturation at both ends
      imm8_instr(OP_LLB, 1, 8'h34), imm8_instr(OP_LHB, 1, 8'h12), imm8_instr(OP_LLB, 2, 8'h11),
      rr_instr(OP_ADD, 3, 1, 2), rr_instr(OP_SUB, 4, 3, 1), rr_instr(OP_XOR, 5, 4, 3),
      imm8_instr(OP_LLB, 6, 8'hFF), imm8_instr(OP_LHB, 6, 8'h7F), rr_instr(OP_ADD, 7, 6, 6),
      imm8_instr(OP_LHB, 8, 8'h80), rr_instr(OP_SUB, 9, 8, 1), HALT,
      // Store and load round trips
      imm8_instr(OP_LLB, 1, 8'h40), imm8_instr(OP_LLB, 2, 8'h5A),
      rr_instr(OP_SW, 2, 1, 0), rr_instr(OP_LW, 3, 1, 0), rr_instr(OP_ADD, 4, 3, 1),
      rr_instr(OP_SW, 4, 1, 1), rr_instr(OP_LW, 5, 1, 1), rr_instr(OP_SW, 5, 1, -1),
      rr_instr(OP_LW, 6, 1, -1), rr_instr(OP_ADD, 7, 6, 2), HALT,
      // Taken and not-taken branches
      imm8_instr(OP_LLB, 1, 8'h05), imm8_instr(OP_LLB, 2, 8'h05), rr_instr(OP_SUB, 3, 1, 2),
      branch_instr(CC_EQ, 1), imm8_instr(OP_LLB, 4, 8'hEE), rr_instr(OP_ADD, 5, 1, 2),
      branch_instr(CC_LT, 1), imm8_instr(OP_LLB, 6, 8'h77), branch_instr(CC_GT, 1),
      imm8_instr(OP_LLB, 7, 8'hEE), rr_instr(OP_SUB, 8, 2, 5), branch_instr(CC_LE, 1),
      imm8_instr(OP_LLB, 9, 8'hEE), branch_instr(CC_OV, 1), imm8_instr(OP_LLB, 10, 8'h3C),
      HALT,
      // Shifts and one word sitting behind HLT
      imm8_instr(OP_LLB, 1, 8'h81), imm8_instr(OP_LHB, 1, 8'hC0), rr_instr(OP_SLL, 2, 1, 4),
      rr_instr(OP_SRA, 3, 1, 4), rr_instr(OP_SRA, 4, 1, 15), rr_instr(OP_SLL, 5, 3, 1),
      rr_instr(OP_SRA, 6, 5, 0), rr_instr(OP_SLL, 7, 1, 15), HALT,
      imm8_instr(OP_LLB, 8, 8'h99)
    };
    wb_q = '{
      20'h1_0034, 20'h1_1234, 20'h2_0011, 20'h3_1245, 20'h4_0011, 20'h5_1254,
      20'h6_00FF, 20'h6_7FFF, 20'h7_7FFF, 20'h8_8000, 20'h9_8000,
      20'h1_0040, 20'h2_005A, 20'h3_005A, 20'h4_009A, 20'h5_009A, 20'h6_009A, 20'h7_00F4,
      20'h1_0005, 20'h2_0005, 20'h3_0000, 20'h5_000A, 20'h6_0077, 20'h8_FFFB, 20'hA_003C,
      20'h1_0081, 20'h1_C081, 20'h2_0810, 20'h3_FC08, 20'h4_FFFF, 20'h5_F810, 20'h6_F810,
      20'h7_8000
    };
    prog_len = '{12, 11, 16, 10};
    hlt_idx  = '{11, 10, 15, 8};
    wb_cnt   = '{11, 7, 7, 8};
  endtask

  ////////////////////
  // Checks
  ////////////////////
  task automatic check_wb(input cpu_pkg::reg_idx_t exp_reg, input cpu_pkg::word_t exp_val);
    if (wb_reg !== exp_reg)
      report_failure($sformatf("MISMATCH wb_reg: got 0x%h, expected 0x%h", wb_reg, exp_reg));
    if (wb_data !== exp_val)
      report_failure($sformatf("MISMATCH wb_data: got 0x%h, expected 0x%h", wb_data, exp_val));
  endtask

  task automatic check_pc(input cpu_pkg::word_t exp_pc);
    if (pc !== exp_pc)
      report_failure($sformatf("MISMATCH pc: got 0x%h, expected 0x%h", pc, exp_pc));
  endtask

  task automatic check_ack(input logic exp_ack);
    if (prog_ack !== exp_ack)
      report_failure($sformatf("MISMATCH prog_ack: got 0x%h, expected 0x%h", prog_ack, exp_ack));
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_n    = 1'b0;
    prog_req = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    if (hlt !== 1'b0 || wb_valid !== 1'b0)
      report_failure("hlt or wb_valid is not low after reset");
  endtask

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
      if (n > ACK_LIMIT)
        report_failure($sformatf("Loader never drove prog_ack to %0d", level));
    end while (prog_ack !== level);
  endtask

  // Four-phase handshake per word
  task automatic load_program(input int base, input int len);
    for (int i = 0; i < len; i++) begin
      prog_addr = 16'(2 * i);
      prog_data = code_q[base + i];
      prog_last = (i == len - 1);
      prog_req  = 1'b1;
      wait_ack(1'b1);
      prog_req = 1'b0;
      wait_ack(1'b0);
    end
    prog_last = 1'b0;
  endtask

  task automatic collect_wb(input int p, input int wb_base, inout int seen);
    logic [19:0] entry;
    if (wb_valid) begin
      if (seen >= wb_cnt[p])
        report_failure($sformatf("Program %0d wrote R%0d after its last expected write",
          p, wb_reg));
      entry = wb_q[wb_base + seen];
      check_wb(entry[19:16], entry[15:0]);
      seen++;
    end
  endtask

  task automatic run_program(input int p, input int wb_base);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    do begin
      @(negedge clk);
      collect_wb(p, wb_base, seen);
      cycles++;
      if (cycles > HLT_LIMIT)
        report_failure($sformatf("hlt did not rise within %0d cycles in program %0d",
          HLT_LIMIT, p));
    end while (hlt !== 1'b1);
    // Older instructions drain while pc sits just past HLT
    repeat (DRAIN_CYCLES) begin
      @(negedge clk);
      collect_wb(p, wb_base, seen);
      check_pc(16'(2 * hlt_idx[p] + 2));
    end
    if (seen != wb_cnt[p])
      report_failure($sformatf("Program %0d is missing writebacks, saw %0d of %0d",
        p, seen, wb_cnt[p]));
  endtask

  initial begin
    int code_base;
    int wb_base;
    int total_words;
    int total_wb;
    rst_n     = 1'b0;
    prog_req  = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    prog_last = 1'b0;
    build_table();
    total_words = 0;
    total_wb    = 0;
    for (int p = 0; p < NPROG; p++) begin
      total_words += prog_len[p];
      total_wb    += wb_cnt[p];
    end
    if (total_words != code_q.size() || total_wb != wb_q.size())
      report_failure("Program table lengths do not match its contents");
    code_base = 0;
    wb_base   = 0;
    for (int p = 0; p < NPROG; p++) begin
      apply_reset();
      check_ack(1'b0);
      check_pc(16'h0000);
      load_program(code_base, prog_len[p]);
      // No request pending, so ack must stay low
      @(posedge clk);
      #1;
      check_ack(1'b0);
      run_program(p, wb_base);
      code_base += prog_len[p];
      wb_base   += wb_cnt[p];
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/cpu_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_props (
  input logic              clk,
  input logic              rst_n,
  input logic              prog_req,
  input logic              prog_ack,
  input logic              hlt,
  input cpu_pkg::word_t    pc,
  input logic              wb_valid,
  input cpu_pkg::reg_idx_t wb_reg
);

  // Ack answers a request seen on the previous edge
  ack_rise_on_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(prog_ack) |-> $past(prog_req))
    else $error("prog_ack rose with no pending prog_req");

  ack_fall_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(prog_ack) |-> !$past(prog_req))
    else $error("prog_ack dropped while prog_req was still high");

  pc_hold_on_hlt: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(hlt) && hlt) |-> $stable(pc))
    else $error("pc moved while hlt was high");

  no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid |-> (wb_reg != '0))
    else $error("writeback reported for R0");

endmodule

bind cpu cpu_props props_inst (
  .clk, .rst_n, .prog_req, .prog_ack, .hlt, .pc, .wb_valid, .wb_reg
);

`default_nettype wire

// ==== cpu/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu #(
  parameter int IMEM_WORDS = 256,
  parameter int DMEM_WORDS = 256
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              prog_req,
  input  cpu_pkg::word_t    prog_addr,
  input  cpu_pkg::word_t    prog_data,
  input  logic              prog_last,
  output logic              prog_ack,
  output logic              hlt,
  output cpu_pkg::word_t    pc,
  output logic              wb_valid,
  output cpu_pkg::reg_idx_t wb_reg,
  output cpu_pkg::word_t    wb_data
);

  logic             run;
  logic             imem_we;
  logic             stall;
  logic             take_branch;
  logic             redirect;
  logic             fetch_hold;
  logic             fwd_store;
  cpu_pkg::word_t   imem_waddr;
  cpu_pkg::word_t   imem_wdata;
  cpu_pkg::word_t   instr;
  cpu_pkg::word_t   pc_plus_2;
  cpu_pkg::word_t   branch_target;
  cpu_pkg::word_t   op_a;
  cpu_pkg::word_t   reg_b;
  cpu_pkg::word_t   alu_result;
  cpu_pkg::word_t   store_wdata;
  cpu_pkg::word_t   dmem_rdata;
  cpu_pkg::flags_t  flags;
  cpu_pkg::fwd_e    fwd_a;
  cpu_pkg::fwd_e    fwd_b;
  cpu_pkg::if_id_t  if_id_d;
  cpu_pkg::if_id_t  if_id_q;
  cpu_pkg::id_ex_t  id_ex_d;
  cpu_pkg::id_ex_t  id_ex_q;
  cpu_pkg::ex_mem_t ex_mem_d;
  cpu_pkg::ex_mem_t ex_mem_q;
  cpu_pkg::mem_wb_t mem_wb_d;
  cpu_pkg::mem_wb_t mem_wb_q;

  rf_if rf_bus ();

  prog_loader loader_inst (.clk, .rst_n, .prog_req, .prog_addr, .prog_data, .prog_last,
    .prog_ack, .imem_we, .imem_waddr, .imem_wdata, .run);

  ////////////////////
  // Fetch
  ////////////////////
  assign redirect   = take_branch && !stall;  // Flags are stale while stalled
  assign fetch_hold = stall || hlt;
  assign pc_plus_2  = pc + 16'd2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (!run) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= branch_target;
    end else if (!fetch_hold) begin
      pc <= pc_plus_2;
    end
  end

  word_mem #(.WORDS(IMEM_WORDS)) imem (.clk, .we(imem_we), .waddr(imem_waddr),
    .wdata(imem_wdata), .raddr(pc), .rdata(instr));

  assign if_id_d = '{instr: instr, pc_plus_2: pc_plus_2};

  pipe_reg #(.payload_t(cpu_pkg::if_id_t)) if_id (.clk, .rst_n, .stall(fetch_hold),
    .flush(redirect || !run), .d(if_id_d), .q(if_id_q));

  // Decode
  reg_file rf_inst (.clk, .rst_n, .rf(rf_bus));
  decode_stage decode_inst (.if_id(if_id_q), .flags, .rf(rf_bus), .id_ex(id_ex_d),
    .take_branch, .branch_target, .hlt);
  hazard_unit hazard_inst (.id_src1(id_ex_d.src1), .id_src2(id_ex_d.src2), .id_op(id_ex_d.op),
    .id_ex(id_ex_q), .ex_mem(ex_mem_q), .mem_wb(mem_wb_q), .fwd_a, .fwd_b, .fwd_store, .stall);

  pipe_reg #(.payload_t(cpu_pkg::id_ex_t)) id_ex (.clk, .rst_n, .stall(1'b0),
    .flush(stall || !run), .d(id_ex_d), .q(id_ex_q));  // Bubble on stall

  ////////////////////
  // Execute
  ////////////////////
  always_comb begin
    case (fwd_a)
      cpu_pkg::FWD_EX_MEM: op_a = ex_mem_q.alu_result;
      cpu_pkg::FWD_MEM_WB: op_a = mem_wb_q.result;
      default:             op_a = id_ex_q.rd1;
    endcase
    case (fwd_b)
      cpu_pkg::FWD_EX_MEM: reg_b = ex_mem_q.alu_result;
      cpu_pkg::FWD_MEM_WB: reg_b = mem_wb_q.result;
      default:             reg_b = id_ex_q.rd2;
    endcase
  end

  alu alu_inst (.clk, .rst_n, .op(id_ex_q.op), .a(op_a),
    .b(id_ex_q.alu_src ? id_ex_q.imm : reg_b), .sets_flags(id_ex_q.sets_flags),
    .result(alu_result), .flags);

  assign ex_mem_d = '{alu_result: alu_result, store_data: reg_b, dst: id_ex_q.dst,
    src2: id_ex_q.src2, mem_read: id_ex_q.mem_read, mem_write: id_ex_q.mem_write,
    reg_write: id_ex_q.reg_write};

  pipe_reg #(.payload_t(cpu_pkg::ex_mem_t)) ex_mem (.clk, .rst_n, .stall(1'b0),
    .flush(!run), .d(ex_mem_d), .q(ex_mem_q));

  // Store data may come from the load just ahead
  assign store_wdata = fwd_store ? mem_wb_q.result : ex_mem_q.store_data;

  word_mem #(.WORDS(DMEM_WORDS)) dmem (.clk, .we(ex_mem_q.mem_write && run),
    .waddr(ex_mem_q.alu_result), .wdata(store_wdata), .raddr(ex_mem_q.alu_result),
    .rdata(dmem_rdata));

  assign mem_wb_d = '{result: ex_mem_q.mem_read ? dmem_rdata : ex_mem_q.alu_result,
    dst: ex_mem_q.dst, reg_write: ex_mem_q.reg_write};

  pipe_reg #(.payload_t(cpu_pkg::mem_wb_t)) mem_wb (.clk, .rst_n, .stall(1'b0),
    .flush(!run), .d(mem_wb_d), .q(mem_wb_q));

  ////////////////////
  // Writeback
  ////////////////////
  assign rf_bus.we    = mem_wb_q.reg_write;
  assign rf_bus.dst   = mem_wb_q.dst;
  assign rf_bus.wdata = mem_wb_q.result;

  assign wb_valid = mem_wb_q.reg_write;  // Decode never sets it for R0
  assign wb_reg   = mem_wb_q.dst;
  assign wb_data  = mem_wb_q.result;

endmodule

`default_nettype wire

// ==== cpu/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  cpu_pkg::if_id_t  if_id,
  input  cpu_pkg::flags_t  flags,
  rf_if.reader             rf,
  output cpu_pkg::id_ex_t  id_ex,
  output logic             take_branch,
  output cpu_pkg::word_t   branch_target,
  output logic             hlt
);

  cpu_pkg::opcode_e  op;
  cpu_pkg::reg_idx_t dst;
  logic              is_arith;
  logic              is_shift;
  logic              is_byte;
  logic              cond_met;

  assign op       = cpu_pkg::opcode_e'(if_id.instr[15:12]);
  assign dst      = if_id.instr[11:8];
  assign is_arith = (op == cpu_pkg::OP_ADD) || (op == cpu_pkg::OP_SUB) || (op == cpu_pkg::OP_XOR);
  assign is_shift = (op == cpu_pkg::OP_SLL) || (op == cpu_pkg::OP_SRA);
  assign is_byte  = (op == cpu_pkg::OP_LLB) || (op == cpu_pkg::OP_LHB);

  assign rf.src1 = is_byte ? dst : if_id.instr[7:4];                  // LLB/LHB modify rd
  assign rf.src2 = (op == cpu_pkg::OP_SW) ? dst : if_id.instr[3:0];  // Store data reg

  // Condition code vs flags
  always_comb begin
    case (if_id.instr[11:9])
      3'b000:  cond_met = !flags.z;
      3'b001:  cond_met = flags.z;
      3'b010:  cond_met = !flags.z && !flags.n;
      3'b011:  cond_met = flags.n;
      3'b100:  cond_met = flags.z || !flags.n;
      3'b101:  cond_met = flags.z || flags.n;
      3'b110:  cond_met = flags.v;
      default: cond_met = 1'b1;
    endcase
  end

  assign take_branch   = (op == cpu_pkg::OP_B) && cond_met;
  assign branch_target = if_id.pc_plus_2 + {{6{if_id.instr[8]}}, if_id.instr[8:0], 1'b0};
  assign hlt           = (op == cpu_pkg::OP_HLT);

  always_comb begin
    id_ex      = '0;
    id_ex.op   = op;
    id_ex.rd1  = rf.rd1;
    id_ex.rd2  = rf.rd2;
    id_ex.dst  = dst;
    id_ex.src1 = rf.src1;
    id_ex.src2 = rf.src2;
    case (op)
      cpu_pkg::OP_LLB:                id_ex.imm = {8'h00, if_id.instr[7:0]};
      cpu_pkg::OP_LHB:                id_ex.imm = {if_id.instr[7:0], 8'h00};
      cpu_pkg::OP_SLL, cpu_pkg::OP_SRA: id_ex.imm = {12'h000, if_id.instr[3:0]};
      default:                        id_ex.imm = {{11{if_id.instr[3]}}, if_id.instr[3:0], 1'b0};
    endcase
    id_ex.alu_src   = is_shift || is_byte || op == cpu_pkg::OP_LW || op == cpu_pkg::OP_SW;
    id_ex.mem_read  = (op == cpu_pkg::OP_LW);
    id_ex.mem_write = (op == cpu_pkg::OP_SW);
    id_ex.reg_write = (is_arith || is_shift || is_byte || op == cpu_pkg::OP_LW) && dst != '0;
    // An all-zero word is a flushed slot and must not touch the flags
    id_ex.sets_flags = is_arith && (if_id.instr != '0);
  end

endmodule

`default_nettype wire

// ==== verilog/prog_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module prog_loader (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           prog_req,
  input  cpu_pkg::word_t prog_addr,
  input  cpu_pkg::word_t prog_data,
  input  logic           prog_last,
  output logic           prog_ack,
  output logic           imem_we,
  output cpu_pkg::word_t imem_waddr,
  output cpu_pkg::word_t imem_wdata,
  output logic           run
);

  typedef enum logic {
    IDLE,
    ACK
  } state_e;

  state_e state;

  // One write per request, on the edge that raises ack
  assign imem_we    = (state == IDLE) && prog_req;
  assign imem_waddr = prog_addr;
  assign imem_wdata = prog_data;
  assign prog_ack   = (state == ACK);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      run   <= 1'b0;
    end else begin
      case (state)
        IDLE: if (prog_req) state <= ACK;
        ACK:  if (!prog_req) state <= IDLE;  // Wait for req to drop
        default: state <= IDLE;
      endcase
      if (imem_we && prog_last) begin
        run <= 1'b1;  // Sticky until reset
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  cpu_pkg::reg_idx_t id_src1,
  input  cpu_pkg::reg_idx_t id_src2,
  input  cpu_pkg::opcode_e  id_op,
  input  cpu_pkg::id_ex_t   id_ex,
  input  cpu_pkg::ex_mem_t  ex_mem,
  input  cpu_pkg::mem_wb_t  mem_wb,
  output cpu_pkg::fwd_e     fwd_a,
  output cpu_pkg::fwd_e     fwd_b,
  output logic              fwd_store,
  output logic              stall
);

  logic uses_src1;
  logic uses_src2;
  logic load_use;

  // Newest producer wins. A load in ex_mem only holds its address
  function automatic cpu_pkg::fwd_e pick(input cpu_pkg::reg_idx_t src,
      input cpu_pkg::ex_mem_t em, input cpu_pkg::mem_wb_t mw);
    if (em.reg_write && !em.mem_read && em.dst != '0 && em.dst == src)
      return cpu_pkg::FWD_EX_MEM;
    if (mw.reg_write && mw.dst != '0 && mw.dst == src)
      return cpu_pkg::FWD_MEM_WB;
    return cpu_pkg::FWD_NONE;
  endfunction

  assign fwd_a = pick(id_ex.src1, ex_mem, mem_wb);
  assign fwd_b = (id_ex.alu_src && !id_ex.mem_write) ? cpu_pkg::FWD_NONE :
                 pick(id_ex.src2, ex_mem, mem_wb);

  // SW data after a load is caught here instead of stalling
  assign fwd_store = ex_mem.mem_write && mem_wb.reg_write && mem_wb.dst != '0 &&
                     mem_wb.dst == ex_mem.src2;

  assign uses_src1 = (id_op != cpu_pkg::OP_B) && (id_op != cpu_pkg::OP_HLT);
  assign uses_src2 = (id_op == cpu_pkg::OP_ADD) || (id_op == cpu_pkg::OP_SUB) ||
                     (id_op == cpu_pkg::OP_XOR);

  assign load_use = id_ex.mem_read && id_ex.dst != '0 &&
                    ((uses_src1 && id_ex.dst == id_src1) || (uses_src2 && id_ex.dst == id_src2));

  // B waits until the flag register has caught up
  assign stall = load_use || (id_op == cpu_pkg::OP_B && id_ex.sets_flags);

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic             clk,
  input  logic             rst_n,
  input  cpu_pkg::opcode_e op,
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  input  logic             sets_flags,
  output cpu_pkg::word_t   result,
  output cpu_pkg::flags_t  flags
);

  cpu_pkg::word_t sum;
  cpu_pkg::word_t diff;
  cpu_pkg::word_t limit;
  logic           add_ovf;
  logic           sub_ovf;
  logic           sat;

  assign sum     = a + b;
  assign diff    = a - b;
  assign add_ovf = (a[15] == b[15]) && (sum[15] != a[15]);
  assign sub_ovf = (a[15] != b[15]) && (diff[15] != a[15]);
  assign limit   = a[15] ? 16'h8000 : 16'h7FFF;  // Clamp toward a's sign

  always_comb begin
    sat = 1'b0;
    case (op)
      cpu_pkg::OP_ADD: begin
        sat    = add_ovf;
        result = add_ovf ? limit : sum;
      end
      cpu_pkg::OP_SUB: begin
        sat    = sub_ovf;
        result = sub_ovf ? limit : diff;
      end
      cpu_pkg::OP_XOR: result = a ^ b;
      cpu_pkg::OP_SLL: result = a << b[3:0];
      cpu_pkg::OP_SRA: result = $signed(a) >>> b[3:0];
      cpu_pkg::OP_LLB: result = {a[15:8], b[7:0]};
      cpu_pkg::OP_LHB: result = {b[15:8], a[7:0]};
      default:         result = sum;  // LW and SW address
    endcase
  end

  ////////////////////
  // Flag register
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (sets_flags) begin
      flags.z <= (result == '0);
      flags.v <= sat;        // XOR leaves it clear
      flags.n <= result[15];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input logic clk,
  input logic rst_n,
  rf_if.regs  rf
);

  cpu_pkg::word_t regs [16];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.we && rf.dst != '0) begin  // R0 stays zero
      regs[rf.dst] <= rf.wdata;
    end
  end

  // Writeback data bypasses straight to decode
  assign rf.rd1 = (rf.we && rf.src1 != '0 && rf.dst == rf.src1) ? rf.wdata : regs[rf.src1];
  assign rf.rd2 = (rf.we && rf.src2 != '0 && rf.dst == rf.src2) ? rf.wdata : regs[rf.src2];

endmodule

`default_nettype wire

// ==== verilog/word_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_mem #(
  parameter int WORDS = 256
) (
  input  logic           clk,
  input  logic           we,
  input  cpu_pkg::word_t waddr,
  input  cpu_pkg::word_t wdata,
  input  cpu_pkg::word_t raddr,
  output cpu_pkg::word_t rdata
);

  localparam int AW = $clog2(WORDS);

  cpu_pkg::word_t mem [WORDS];

  // Byte address, so bit 0 is dropped
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr[AW:1]] <= wdata;
    end
  end

  assign rdata = mem[raddr[AW:1]];  // Combinational read

endmodule

`default_nettype wire

// ==== verilog/pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     stall,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // Zero payload is a bubble in every stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else if (stall) begin
      q <= q;
    end else if (flush) begin
      q <= '0;
    end else begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// ==== common/rf_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface rf_if;

  cpu_pkg::reg_idx_t src1;
  cpu_pkg::reg_idx_t src2;
  cpu_pkg::word_t    rd1;
  cpu_pkg::word_t    rd2;
  logic              we;
  cpu_pkg::reg_idx_t dst;
  cpu_pkg::word_t    wdata;

  modport reader (output src1, output src2, input rd1, input rd2);
  modport writer (output we, output dst, output wdata);
  modport regs (
    input  src1, input src2, input we, input dst, input wdata,
    output rd1, output rd2
  );

endinterface

`default_nettype wire

// ==== common/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  typedef logic [15:0] word_t;
  typedef logic [3:0]  reg_idx_t;

  typedef enum logic [3:0] {
    OP_ADD = 4'h0,
    OP_SUB = 4'h1,
    OP_XOR = 4'h2,
    OP_SLL = 4'h4,
    OP_SRA = 4'h5,
    OP_LW  = 4'h8,
    OP_SW  = 4'h9,
    OP_LLB = 4'hA,
    OP_LHB = 4'hB,
    OP_B   = 4'hC,
    OP_HLT = 4'hF
  } opcode_e;

  // Operand source for the execute and store muxes
  typedef enum logic [1:0] {
    FWD_NONE   = 2'd0,
    FWD_EX_MEM = 2'd1,
    FWD_MEM_WB = 2'd2
  } fwd_e;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flags_t;

  typedef struct packed {
    word_t instr;
    word_t pc_plus_2;
  } if_id_t;

  typedef struct packed {
    opcode_e  op;
    word_t    rd1;
    word_t    rd2;
    word_t    imm;         // Already shaped for the ALU
    reg_idx_t dst;
    reg_idx_t src1;
    reg_idx_t src2;
    logic     alu_src;     // Operand 2 from imm
    logic     mem_read;
    logic     mem_write;
    logic     reg_write;
    logic     sets_flags;
  } id_ex_t;

  typedef struct packed {
    word_t    alu_result;
    word_t    store_data;
    reg_idx_t dst;
    reg_idx_t src2;
    logic     mem_read;
    logic     mem_write;
    logic     reg_write;
  } ex_mem_t;

  typedef struct packed {
    word_t    result;
    reg_idx_t dst;
    logic     reg_write;
  } mem_wb_t;

endpackage

`default_nettype wire
